/* hdl/mcu_pkg.sv */
package mcu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;
    typedef logic [15:0] gpio_t;
    typedef logic [1:0]  region_t;
    typedef logic [1:0]  ofs_t;

    // Region code sits in address bits 13:12
    localparam region_t REGION_GPIO  = 2'd0;
    localparam region_t REGION_UART  = 2'd1;
    localparam region_t REGION_TIMER = 2'd2;
    localparam region_t REGION_NONE  = 2'd3;

    // Word offsets within a region, address bits 3:2
    localparam ofs_t OFS_GPIO_OUT  = 2'd0;
    localparam ofs_t OFS_GPIO_IN   = 2'd1;
    localparam ofs_t OFS_UART_DATA = 2'd0;
    localparam ofs_t OFS_UART_STAT = 2'd1;
    localparam ofs_t OFS_TMR_CTRL  = 2'd0;
    localparam ofs_t OFS_TMR_CMP   = 2'd1;
    localparam ofs_t OFS_TMR_CNT   = 2'd2;

    // UART status word bits
    localparam int STAT_TX_BUSY  = 0;
    localparam int STAT_RX_VALID = 1;

    localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

    typedef struct packed {
        logic  we;
        be_t   be;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  wr;
        logic  rd;
        ofs_t  ofs;
        be_t   be;
        data_t wdata;
    } access_t;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

endpackage

/* hdl/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              data_req_i,
    input  mcu_pkg::bus_req_t data_i,
    output logic              data_gnt_o,
    output logic              acc_valid_o,
    output mcu_pkg::access_t  gpio_acc_o,
    output mcu_pkg::access_t  uart_acc_o,
    output mcu_pkg::access_t  tmr_acc_o,
    output mcu_pkg::region_t  region_o
);
    import mcu_pkg::*;

    region_t    region;
    logic [2:0] sel;
    logic [2:0] wr_q;
    logic [2:0] rd_q;
    ofs_t       ofs_q;
    be_t        be_q;
    data_t      wdata_q;

    // No back-pressure, every request is taken at once
    assign data_gnt_o = data_req_i;

    assign region = data_i.addr[13:12];
    // One-hot region select, shifting out to zero for the unmapped code
    assign sel = data_req_i ? (3'b001 << region) : 3'b000;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_q        <= '0;
            rd_q        <= '0;
            acc_valid_o <= 1'b0;
            region_o    <= REGION_NONE;
        end else begin
            wr_q        <= sel & {3{data_i.we}};
            rd_q        <= sel & {3{~data_i.we}};
            acc_valid_o <= data_req_i;
            region_o    <= region;
        end
    end

    // Shared payload for whichever region got the strobe
    always_ff @(posedge clk_i) begin
        if (data_req_i) begin
            ofs_q   <= data_i.addr[3:2];
            be_q    <= data_i.be;
            wdata_q <= data_i.wdata;
        end
    end

    assign gpio_acc_o = '{wr: wr_q[REGION_GPIO], rd: rd_q[REGION_GPIO],
                          ofs: ofs_q, be: be_q, wdata: wdata_q};
    assign uart_acc_o = '{wr: wr_q[REGION_UART], rd: rd_q[REGION_UART],
                          ofs: ofs_q, be: be_q, wdata: wdata_q};
    assign tmr_acc_o  = '{wr: wr_q[REGION_TIMER], rd: rd_q[REGION_TIMER],
                          ofs: ofs_q, be: be_q, wdata: wdata_q};

endmodule

/* hdl/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  mcu_pkg::access_t acc_i,
    input  mcu_pkg::gpio_t   gpio_i,
    output mcu_pkg::gpio_t   gpio_o,
    output mcu_pkg::data_t   rdata_o
);
    import mcu_pkg::*;

    gpio_t in_meta_q;
    gpio_t in_sync_q;
    gpio_t out_q;

    // Two-flop synchroniser on the pins
    always_ff @(posedge clk_i) begin
        in_meta_q <= gpio_i;
        in_sync_q <= in_meta_q;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (acc_i.wr && acc_i.ofs == OFS_GPIO_OUT) begin
            // Only the low two lanes exist
            if (acc_i.be[0]) out_q[7:0]  <= acc_i.wdata[7:0];
            if (acc_i.be[1]) out_q[15:8] <= acc_i.wdata[15:8];
        end
    end

    assign gpio_o = out_q;

    always_comb begin
        rdata_o = '0;
        if (acc_i.rd) begin
            case (acc_i.ofs)
                OFS_GPIO_OUT: rdata_o = data_t'(out_q);
                OFS_GPIO_IN:  rdata_o = data_t'(in_sync_q);
                default:      rdata_o = '0;
            endcase
        end
    end

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  mcu_pkg::access_t acc_i,
    output logic             tx_o,
    output logic             busy_o
);
    import mcu_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    uart_state_e      state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             bit_done;
    logic             start_req;

    assign bit_done  = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign start_req = acc_i.wr && (acc_i.ofs == OFS_UART_DATA);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
        end else if (state_q == IDLE) begin
            // Writes during a frame fall through here unseen
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            if (start_req) state_q <= START;
        end else if (!bit_done) begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end else begin
            clk_cnt_q <= '0;
            case (state_q)
                START:   state_q <= DATA;
                DATA: begin
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) state_q <= STOP;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_req) shift_q <= acc_i.wdata[7:0];
        else if (state_q == DATA && bit_done) shift_q <= {1'b0, shift_q[7:1]};
    end

    always_comb begin
        case (state_q)
            START:   tx_o = 1'b0;
            DATA:    tx_o = shift_q[0];
            default: tx_o = 1'b1;
        endcase
    end

    assign busy_o = (state_q != IDLE);

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  mcu_pkg::access_t acc_i,
    input  logic             rx_i,
    input  logic             tx_busy_i,
    output mcu_pkg::data_t   rdata_o
);
    import mcu_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    uart_state_e      state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic [7:0]       rx_data_q;
    logic             rx_valid_q;
    logic             rx_meta_q;
    logic             rx_sync_q;
    logic             rx_prev_q;
    logic             start_edge;
    logic             mid_start;
    logic             bit_done;
    logic             data_rd;

    // Line idles high, so the sync chain resets to one
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    assign start_edge = rx_prev_q && !rx_sync_q;
    assign mid_start  = (clk_cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_done   = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign data_rd    = acc_i.rd && (acc_i.ofs == OFS_UART_DATA);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            rx_data_q  <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
            // Reading the data clears valid, a new byte wins below
            if (data_rd) rx_valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    clk_cnt_q <= '0;
                    bit_idx_q <= '0;
                    if (start_edge) state_q <= START;
                end
                START: if (mid_start) begin
                    // Glitch check at the centre of the start bit
                    clk_cnt_q <= '0;
                    state_q   <= rx_sync_q ? IDLE : DATA;
                end
                DATA: if (bit_done) begin
                    clk_cnt_q <= '0;
                    shift_q   <= {rx_sync_q, shift_q[7:1]};
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) state_q <= STOP;
                end
                default: if (bit_done) begin
                    state_q <= IDLE;
                    if (rx_sync_q) begin
                        rx_data_q  <= shift_q;
                        rx_valid_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        rdata_o = '0;
        if (acc_i.rd) begin
            case (acc_i.ofs)
                OFS_UART_DATA: rdata_o = data_t'(rx_data_q);
                OFS_UART_STAT: begin
                    rdata_o[STAT_TX_BUSY]  = tx_busy_i;
                    rdata_o[STAT_RX_VALID] = rx_valid_q;
                end
                default:       rdata_o = '0;
            endcase
        end
    end

endmodule

/* hdl/timer_irq.sv */
`timescale 1ns/1ps

module timer_irq (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  mcu_pkg::access_t acc_i,
    input  logic             irq_ack_i,
    input  logic [4:0]       irq_id_i,
    output logic             irq_o,
    output mcu_pkg::data_t   rdata_o
);
    import mcu_pkg::*;

    logic  enable_q;
    logic  pending_q;
    data_t cmp_q;
    data_t cnt_q;
    logic  match;
    logic  cnt_wr;
    logic  ack_hit;

    assign match   = enable_q && (cnt_q == cmp_q);
    assign cnt_wr  = acc_i.wr && (acc_i.ofs == OFS_TMR_CNT);
    assign ack_hit = irq_ack_i && (irq_id_i == TIMER_IRQ_ID);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
            cmp_q     <= '0;
            cnt_q     <= '0;
        end else begin
            if (acc_i.wr && acc_i.ofs == OFS_TMR_CTRL) enable_q <= acc_i.wdata[0];
            if (acc_i.wr && acc_i.ofs == OFS_TMR_CMP)  cmp_q    <= acc_i.wdata;

            // Software load beats the free count
            if (cnt_wr)        cnt_q <= acc_i.wdata;
            else if (match)    cnt_q <= '0;
            else if (enable_q) cnt_q <= cnt_q + 1'b1;

            // A fresh match in the ack cycle keeps the line up
            if (ack_hit) pending_q <= 1'b0;
            if (match && !cnt_wr) pending_q <= 1'b1;
        end
    end

    assign irq_o = pending_q;

    always_comb begin
        rdata_o = '0;
        if (acc_i.rd) begin
            case (acc_i.ofs)
                OFS_TMR_CTRL: rdata_o = data_t'(enable_q);
                OFS_TMR_CMP:  rdata_o = cmp_q;
                OFS_TMR_CNT:  rdata_o = cnt_q;
                default:      rdata_o = '0;
            endcase
        end
    end

endmodule

/* hdl/bus_response.sv */
`timescale 1ns/1ps

module bus_response (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  mcu_pkg::region_t region_i,
    input  logic             valid_i,
    input  mcu_pkg::data_t   gpio_rdata_i,
    input  mcu_pkg::data_t   uart_rdata_i,
    input  mcu_pkg::data_t   tmr_rdata_i,
    output logic             data_rvalid_o,
    output mcu_pkg::data_t   data_rdata_o
);
    import mcu_pkg::*;

    data_t rdata_sel;

    // Peripherals drive zero unless read, so writes answer with zero
    always_comb begin
        case (region_i)
            REGION_GPIO:  rdata_sel = gpio_rdata_i;
            REGION_UART:  rdata_sel = uart_rdata_i;
            REGION_TIMER: rdata_sel = tmr_rdata_i;
            default:      rdata_sel = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_rvalid_o <= 1'b0;
        end else begin
            data_rvalid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_rdata_o <= rdata_sel;
    end

endmodule

/* hdl/mcu_periph.sv */
`timescale 1ns/1ps

module mcu_periph #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              data_req_i,
    input  mcu_pkg::bus_req_t data_i,
    output logic              data_gnt_o,
    output logic              data_rvalid_o,
    output mcu_pkg::data_t    data_rdata_o,
    input  mcu_pkg::gpio_t    gpio_i,
    output mcu_pkg::gpio_t    gpio_o,
    input  logic              uart_rx_i,
    output logic              uart_tx_o,
    output logic              irq_o,
    input  logic              irq_ack_i,
    input  logic [4:0]        irq_id_i
);
    import mcu_pkg::*;

    access_t gpio_acc;
    access_t uart_acc;
    access_t tmr_acc;
    region_t region;
    logic    acc_valid;
    logic    tx_busy;
    data_t   gpio_rdata;
    data_t   uart_rdata;
    data_t   tmr_rdata;

    bus_decode u_bus_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .data_req_i  (data_req_i),
        .data_i      (data_i),
        .data_gnt_o  (data_gnt_o),
        .acc_valid_o (acc_valid),
        .gpio_acc_o  (gpio_acc),
        .uart_acc_o  (uart_acc),
        .tmr_acc_o   (tmr_acc),
        .region_o    (region)
    );

    gpio_port u_gpio_port (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .acc_i   (gpio_acc),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .rdata_o (gpio_rdata)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .acc_i   (uart_acc),
        .tx_o    (uart_tx_o),
        .busy_o  (tx_busy)
    );

    // Receiver also builds the status word, so it sees tx busy
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .acc_i     (uart_acc),
        .rx_i      (uart_rx_i),
        .tx_busy_i (tx_busy),
        .rdata_o   (uart_rdata)
    );

    timer_irq u_timer_irq (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .acc_i     (tmr_acc),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .irq_o     (irq_o),
        .rdata_o   (tmr_rdata)
    );

    bus_response u_bus_response (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .region_i      (region),
        .valid_i       (acc_valid),
        .gpio_rdata_i  (gpio_rdata),
        .uart_rdata_i  (uart_rdata),
        .tmr_rdata_i   (tmr_rdata),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o)
    );

endmodule

/* tb/tb_mcu_periph.sv */
`timescale 1ns/1ps

module tb_mcu_periph;
    import mcu_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int WAIT_LIMIT   = 40;
    localparam int POLL_LIMIT   = 60;
    localparam int MIX_OPS      = 200;
    localparam logic [31:0] SEED = 32'h57b4_27b9;

    logic       clk_i;
    logic       rst_n_i;
    logic       data_req_i;
    bus_req_t   data_i;
    logic       data_gnt_o;
    logic       data_rvalid_o;
    data_t      data_rdata_o;
    gpio_t      gpio_i;
    gpio_t      gpio_o;
    logic       uart_rx_i;
    logic       uart_tx_o;
    logic       irq_o;
    logic       irq_ack_i;
    logic [4:0] irq_id_i;

    // Register model
    gpio_t      gpio_out_m;
    gpio_t      gpio_in_m;
    logic       tmr_en_m;
    data_t      tmr_cmp_m;
    data_t      tmr_cnt_m;
    logic       tmr_cnt_known;
    logic [7:0] rx_byte_m;

    int    errors;
    int    checks;
    int    tests;
    int    test_errs;
    string cur_test;

    mcu_periph #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_mcu_periph (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_req_i    (data_req_i),
        .data_i        (data_i),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .gpio_i        (gpio_i),
        .gpio_o        (gpio_o),
        .uart_rx_i     (uart_rx_i),
        .uart_tx_o     (uart_tx_o),
        .irq_o         (irq_o),
        .irq_ack_i     (irq_ack_i),
        .irq_id_i      (irq_id_i)
    );

    // Serial loopback
    assign uart_rx_i = uart_tx_o;

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic data_t rand32();
        return $urandom();
    endfunction

    function automatic addr_t reg_addr(region_t region, ofs_t ofs);
        return {18'b0, region, 8'b0, ofs, 2'b00};
    endfunction

    // Per-byte update of the GPIO output, lanes 0 and 1 only
    function automatic gpio_t merge_gpio(gpio_t old, data_t wdata, be_t be);
        gpio_t res;
        res = old;
        if (be[0]) res[7:0] = wdata[7:0];
        if (be[1]) res[15:8] = wdata[15:8];
        return res;
    endfunction

    function automatic data_t gpio_read_model(ofs_t ofs);
        case (ofs)
            OFS_GPIO_OUT: return data_t'(gpio_out_m);
            OFS_GPIO_IN:  return data_t'(gpio_in_m);
            default:      return '0;
        endcase
    endfunction

    function automatic data_t timer_read_model(ofs_t ofs);
        case (ofs)
            OFS_TMR_CTRL: return data_t'(tmr_en_m);
            OFS_TMR_CMP:  return tmr_cmp_m;
            OFS_TMR_CNT:  return tmr_cnt_m;
            default:      return '0;
        endcase
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            $display("ERR [%s] %s: expected %08h, actual %08h", cur_test, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
        checks++;
        if (act !== exp) begin
            $display("ERR [%s] %s: expected %04h, actual %04h", cur_test, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("ERR [%s] %s: expected %0b, actual %0b", cur_test, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("sim failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests++;
        if (test_errs == 0) $display("test %s: ok", cur_test);
        else $display("test %s: %0d errors", cur_test, test_errs);
    endtask

    // One request, then wait for its response
    task automatic bus_access(input logic write, input addr_t addr, input be_t be,
                              input data_t wdata, output data_t rdata);
        int n;
        n = 0;
        @(posedge clk_i);
        data_req_i <= 1'b1;
        data_i     <= '{we: write, be: be, addr: addr, wdata: wdata};
        @(posedge clk_i);
        data_req_i <= 1'b0;
        @(negedge clk_i);
        while (data_rvalid_o !== 1'b1) begin
            if (n == WAIT_LIMIT) abort_run("no data_rvalid_o after a request");
            @(negedge clk_i);
            n++;
        end
        rdata = data_rdata_o;
    endtask

    task automatic bus_write(input addr_t addr, input be_t be, input data_t wdata);
        data_t rd;
        bus_access(1'b1, addr, be, wdata, rd);
        check_data("write response", '0, rd);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_access(1'b0, addr, 4'hf, '0, rdata);
    endtask

    task automatic read_expect(input string name, input addr_t addr, input data_t exp);
        data_t rd;
        bus_read(addr, rd);
        check_data(name, exp, rd);
    endtask

    // Two synchroniser flops plus one spare cycle
    task automatic drive_gpio_in(input gpio_t value);
        @(posedge clk_i);
        gpio_i <= value;
        gpio_in_m = value;
        repeat (3) @(posedge clk_i);
    endtask

    task automatic pulse_ack(input logic [4:0] id);
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic update_timer_model(input ofs_t ofs, input data_t wdata);
        case (ofs)
            OFS_TMR_CTRL: begin
                tmr_en_m = wdata[0];
                if (wdata[0]) tmr_cnt_known = 1'b0;
            end
            OFS_TMR_CMP:  tmr_cmp_m = wdata;
            OFS_TMR_CNT: begin
                tmr_cnt_m     = wdata;
                tmr_cnt_known = !tmr_en_m;
            end
            default: ;
        endcase
    endtask

    task automatic test_reset();
        start_test("reset");
        check_bit("data_rvalid_o after reset", 1'b0, data_rvalid_o);
        check_bit("irq_o after reset", 1'b0, irq_o);
        check_bit("uart_tx_o after reset", 1'b1, uart_tx_o);
        check_gpio("gpio_o after reset", '0, gpio_o);
        read_expect("timer ctrl after reset", reg_addr(REGION_TIMER, OFS_TMR_CTRL), '0);
        end_test();
    endtask

    task automatic test_gpio();
        data_t wdata;
        data_t r;
        be_t   be;
        start_test("gpio");
        for (int i = 0; i < 20; i++) begin
            wdata = rand32();
            r     = rand32();
            be    = r[3:0];
            bus_write(reg_addr(REGION_GPIO, OFS_GPIO_OUT), be, wdata);
            gpio_out_m = merge_gpio(gpio_out_m, wdata, be);
            check_gpio("gpio_o after write", gpio_out_m, gpio_o);
            read_expect("gpio out readback", reg_addr(REGION_GPIO, OFS_GPIO_OUT),
                        data_t'(gpio_out_m));
            drive_gpio_in(r[31:16]);
            read_expect("gpio in readback", reg_addr(REGION_GPIO, OFS_GPIO_IN),
                        data_t'(gpio_in_m));
        end
        end_test();
    endtask

    // Write, read of the same register and unmapped read, back to back
    task automatic test_pipeline();
        bus_req_t reqs [3];
        data_t    exp_rdata [3];
        data_t    r;
        gpio_t    val;
        start_test("pipeline");
        r   = rand32();
        val = r[15:0];
        reqs[0] = '{we: 1'b1, be: 4'b0011, addr: reg_addr(REGION_GPIO, OFS_GPIO_OUT), wdata: r};
        reqs[1] = '{we: 1'b0, be: 4'b1111, addr: reg_addr(REGION_GPIO, OFS_GPIO_OUT), wdata: '0};
        reqs[2] = '{we: 1'b0, be: 4'b1111, addr: reg_addr(REGION_NONE, 2'd1), wdata: '0};
        exp_rdata = '{32'h0, {16'h0, val}, 32'h0};
        gpio_out_m = val;
        for (int k = 0; k < 6; k++) begin
            @(posedge clk_i);
            if (k < 3) begin
                data_req_i <= 1'b1;
                data_i     <= reqs[k];
            end else begin
                data_req_i <= 1'b0;
            end
            @(negedge clk_i);
            check_bit("data_gnt_o", k < 3, data_gnt_o);
            check_bit("data_rvalid_o", k >= 2 && k < 5, data_rvalid_o);
            if (k >= 2 && k < 5) check_data("pipelined rdata", exp_rdata[k-2], data_rdata_o);
        end
        end_test();
    endtask

    task automatic test_uart();
        data_t      r;
        data_t      stat;
        logic [7:0] tx_byte;
        logic [7:0] late_byte;
        int         n;
        start_test("uart");
        r         = rand32();
        tx_byte   = r[7:0];
        late_byte = ~tx_byte;
        bus_write(reg_addr(REGION_UART, OFS_UART_DATA), 4'b0001, data_t'(tx_byte));
        bus_read(reg_addr(REGION_UART, OFS_UART_STAT), stat);
        check_bit("uart busy after write", 1'b1, stat[STAT_TX_BUSY]);
        // Lands mid-frame, must not reach the line
        bus_write(reg_addr(REGION_UART, OFS_UART_DATA), 4'b0001, data_t'(late_byte));
        n = 0;
        while (stat[STAT_TX_BUSY] !== 1'b0) begin
            if (n == POLL_LIMIT) abort_run("uart tx busy never cleared");
            bus_read(reg_addr(REGION_UART, OFS_UART_STAT), stat);
            n++;
        end
        // Rx valid only
        read_expect("uart status after frame", reg_addr(REGION_UART, OFS_UART_STAT), 32'h2);
        read_expect("uart rx data", reg_addr(REGION_UART, OFS_UART_DATA), data_t'(tx_byte));
        rx_byte_m = tx_byte;
        read_expect("uart status after data read", reg_addr(REGION_UART, OFS_UART_STAT), '0);
        end_test();
    endtask

    task automatic test_timer();
        data_t      r;
        data_t      cmp;
        data_t      cnt;
        logic [4:0] bad_id;
        int         n;
        int         limit;
        start_test("timer");
        r      = rand32();
        cmp    = data_t'(r[4:0]) + 32'd8;
        bad_id = r[12:8];
        if (bad_id == TIMER_IRQ_ID) bad_id = 5'd3;
        limit = int'(cmp) + 10;
        bus_write(reg_addr(REGION_TIMER, OFS_TMR_CNT), 4'hf, '0);
        bus_write(reg_addr(REGION_TIMER, OFS_TMR_CMP), 4'hf, cmp);
        bus_write(reg_addr(REGION_TIMER, OFS_TMR_CTRL), 4'hf, 32'h1);
        n = 0;
        while (irq_o !== 1'b1) begin
            if (n == limit) abort_run("timer interrupt never raised");
            @(negedge clk_i);
            n++;
        end
        pulse_ack(bad_id);
        check_bit("irq_o after wrong id ack", 1'b1, irq_o);
        pulse_ack(TIMER_IRQ_ID);
        check_bit("irq_o after ack", 1'b0, irq_o);
        bus_read(reg_addr(REGION_TIMER, OFS_TMR_CNT), cnt);
        check_bit("timer count within compare", 1'b1, cnt <= cmp);
        // A later match may have fired again before the disable
        bus_write(reg_addr(REGION_TIMER, OFS_TMR_CTRL), 4'hf, '0);
        pulse_ack(TIMER_IRQ_ID);
        check_bit("irq_o after disable", 1'b0, irq_o);
        tmr_en_m      = 1'b0;
        tmr_cmp_m     = cmp;
        tmr_cnt_known = 1'b0;
        end_test();
    endtask

    task automatic test_mix();
        data_t r;
        data_t wdata;
        data_t rd;
        ofs_t  ofs;
        be_t   be;
        start_test("random mix");
        for (int i = 0; i < MIX_OPS; i++) begin
            r     = rand32();
            wdata = rand32();
            ofs   = r[5:4];
            be    = r[11:8];
            case (r[2:0])
                3'd0: begin
                    bus_write(reg_addr(REGION_GPIO, ofs), be, wdata);
                    if (ofs == OFS_GPIO_OUT) gpio_out_m = merge_gpio(gpio_out_m, wdata, be);
                    check_gpio("mix gpio_o", gpio_out_m, gpio_o);
                end
                3'd1: read_expect("mix gpio read", reg_addr(REGION_GPIO, ofs),
                                  gpio_read_model(ofs));
                3'd2: begin
                    drive_gpio_in(wdata[15:0]);
                    read_expect("mix gpio in", reg_addr(REGION_GPIO, OFS_GPIO_IN),
                                data_t'(gpio_in_m));
                end
                3'd3: begin
                    // Status writes have no effect
                    if (r[12]) bus_write(reg_addr(REGION_UART, OFS_UART_STAT), be, wdata);
                    else read_expect("mix uart status", reg_addr(REGION_UART, OFS_UART_STAT), '0);
                end
                3'd4: read_expect("mix uart data", reg_addr(REGION_UART, OFS_UART_DATA),
                                  data_t'(rx_byte_m));
                3'd5: begin
                    bus_write(reg_addr(REGION_TIMER, ofs), 4'hf, wdata);
                    update_timer_model(ofs, wdata);
                end
                3'd6: begin
                    if (ofs == OFS_TMR_CNT && !tmr_cnt_known) ofs = OFS_TMR_CMP;
                    read_expect("mix timer read", reg_addr(REGION_TIMER, ofs),
                                timer_read_model(ofs));
                end
                default: begin
                    bus_access(r[12], reg_addr(REGION_NONE, ofs), be, wdata, rd);
                    check_data("mix unmapped", '0, rd);
                end
            endcase
        end
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i       = 1'b0;
        data_req_i    = 1'b0;
        data_i        = '0;
        gpio_i        = '0;
        irq_ack_i     = 1'b0;
        irq_id_i      = '0;
        gpio_out_m    = '0;
        gpio_in_m     = '0;
        tmr_en_m      = 1'b0;
        tmr_cmp_m     = '0;
        tmr_cnt_m     = '0;
        tmr_cnt_known = 1'b1;
        rx_byte_m     = '0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        test_errs     = 0;
        cur_test      = "";
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        test_reset();
        test_gpio();
        test_pipeline();
        test_uart();
        test_timer();
        test_mix();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* mcu_periph.f */
hdl/mcu_pkg.sv
hdl/bus_decode.sv
hdl/gpio_port.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/timer_irq.sv
hdl/bus_response.sv
hdl/mcu_periph.sv
tb/tb_mcu_periph.sv

/* Makefile */
# Verilator build for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mcu_periph
FILELIST  ?= mcu_periph.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
